// File: hdl/radio_defs.svh
`ifndef RADIO_DEFS_SVH
`define RADIO_DEFS_SVH

// --------------------------------------------------
// Receiver count, 1 to 7
// --------------------------------------------------
`define RADIO_NR 3

// Frequency to phase step for a 76.8 MHz clock
// M2 is 2^57 / fclk
`define RADIO_M2 32'd1876499845
// Rounding term, 2^24
`define RADIO_M3 32'd16777216
// Low bit of the 32-bit phase slice in the product
`define RADIO_PHASE_LSB 25

// Command addresses
`define ADDR_CTRL 6'h00
`define ADDR_TX0 6'h01
`define ADDR_RX0 6'h02
`define ADDR_RX1 6'h03

// Full CW envelope level
`define CW_MAX_LEVEL 19'h4d800

`endif

// File: hdl/radio_ctrl_pkg.sv
`include "radio_defs.svh"

package radio_ctrl_pkg;

  // --------------------------------------------------
  // Scalar widths
  // --------------------------------------------------
  // NCO phase increment
  typedef logic [31:0] phase_t;
  // Receiver channel number
  typedef logic [4:0] chan_t;
  // Command slave address and data
  typedef logic [5:0] cmd_addr_t;
  typedef logic [31:0] cmd_data_t;
  // CW envelope amplitude
  typedef logic [18:0] cw_level_t;

  // --------------------------------------------------
  // Control bundles
  // --------------------------------------------------
  // Settings from the control word at address 0
  typedef struct packed {
    chan_t last_chan;
    logic  duplex;
  } radio_ctrl_t;

  // Latched frequency request, commit pulses once
  typedef struct packed {
    cmd_addr_t addr;
    cmd_data_t data;
    logic      commit;
  } freq_wr_t;

  // One phase word per receiver
  typedef phase_t [`RADIO_NR-1:0] phase_bank_t;

endpackage

// File: hdl/radio_stream_pkg.sv
`include "radio_defs.svh"

package radio_stream_pkg;

  // Receiver output sample, two's complement
  typedef logic signed [23:0] sample_t;

  // I and Q of one receiver
  typedef struct packed {
    sample_t i;
    sample_t q;
  } iq_sample_t;

  // Samples of all receivers at one strobe
  typedef iq_sample_t [`RADIO_NR-1:0] iq_bank_t;

  // One upstream beat, last marks the end of a frame
  typedef struct packed {
    sample_t data;
    logic    last;
  } rx_beat_t;

endpackage

// File: hdl/cmd_decoder.sv
`timescale 1ns/1ps
`include "radio_defs.svh"

module cmd_decoder import radio_ctrl_pkg::*; (
  input  logic        clk,
  input  logic        rst_n_i,
  input  logic        cmd_rqst_i,
  input  cmd_addr_t   cmd_addr_i,
  input  cmd_data_t   cmd_data_i,
  output logic        cmd_ack_o,
  output radio_ctrl_t ctrl_o,
  output freq_wr_t    freq_wr_o
);

  // Idle, then three cycles for the phase multiply
  typedef enum logic [1:0] {
    CMD_IDLE,
    CMD_FREQ1,
    CMD_FREQ2,
    CMD_FREQ3
  } cmd_state_t;

  cmd_state_t  state_q;
  radio_ctrl_t ctrl_q;
  cmd_addr_t   addr_q;
  cmd_data_t   data_q;
  logic        is_ctrl;
  logic        is_freq;
  chan_t       chan_req;
  chan_t       chan_sat;

  // --------------------------------------------------
  // Address decode
  // --------------------------------------------------
  assign is_ctrl = (cmd_addr_i == `ADDR_CTRL);
  // TX0 plus one RX address per receiver
  assign is_freq = (cmd_addr_i >= `ADDR_TX0) &&
                   (cmd_addr_i <= cmd_addr_t'(`ADDR_RX0 + `RADIO_NR - 1));

  // Last channel field, clipped to the highest receiver
  assign chan_req = cmd_data_i[7:3];
  assign chan_sat = (chan_req > chan_t'(`RADIO_NR - 1)) ? chan_t'(`RADIO_NR - 1) : chan_req;

  // --------------------------------------------------
  // Command FSM and control registers
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= CMD_IDLE;
      ctrl_q  <= '0;
    end else begin
      case (state_q)
        CMD_IDLE: begin
          // Control writes take effect here, no ack
          if (cmd_rqst_i && is_ctrl) begin
            ctrl_q.last_chan <= chan_sat;
            ctrl_q.duplex    <= cmd_data_i[2];
          end
          if (cmd_rqst_i && is_freq) state_q <= CMD_FREQ1;
        end
        CMD_FREQ1: state_q <= CMD_FREQ2;
        CMD_FREQ2: state_q <= CMD_FREQ3;
        default:   state_q <= CMD_IDLE;
      endcase
    end
  end

  // Request fields only held for the accept cycle
  always_ff @(posedge clk) begin
    if (state_q == CMD_IDLE && cmd_rqst_i && is_freq) begin
      addr_q <= cmd_addr_i;
      data_q <= cmd_data_i;
    end
  end

  // Ack and commit together in the last busy cycle
  assign cmd_ack_o = (state_q == CMD_FREQ3);
  assign ctrl_o    = ctrl_q;

  always_comb begin
    freq_wr_o.addr   = addr_q;
    freq_wr_o.data   = data_q;
    freq_wr_o.commit = (state_q == CMD_FREQ3);
  end

endmodule

// File: hdl/phase_table.sv
`timescale 1ns/1ps
`include "radio_defs.svh"

module phase_table import radio_ctrl_pkg::*; (
  input  logic        clk,
  input  logic        rst_n_i,
  input  freq_wr_t    freq_wr_i,
  input  radio_ctrl_t ctrl_i,
  output phase_t      tx_phase_o,
  output phase_bank_t rx_phase_o
);

  logic [63:0] prod_q;
  phase_t      phase_q;
  phase_t      tx_q;
  phase_bank_t rx_q;
  logic        simplex;

  // --------------------------------------------------
  // Multiply and round, two register stages
  // --------------------------------------------------
  // Request data is stable from the accept edge, so the
  // slice is settled by the commit cycle
  always_ff @(posedge clk) begin
    prod_q  <= 64'(freq_wr_i.data) * 64'(`RADIO_M2) + 64'(`RADIO_M3);
    phase_q <= prod_q[`RADIO_PHASE_LSB +: 32];
  end

  // RX0 follows TX0 with one receiver and no duplex
  assign simplex = !ctrl_i.duplex && (ctrl_i.last_chan == '0);

  // --------------------------------------------------
  // Phase registers
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      tx_q <= '0;
      rx_q <= '0;
    end else if (freq_wr_i.commit) begin
      if (freq_wr_i.addr == `ADDR_TX0) begin
        tx_q <= phase_q;
        if (simplex) rx_q[0] <= phase_q;
      end
      // Simplex takes the current TX0 word, not the new one
      if (freq_wr_i.addr == `ADDR_RX0) begin
        rx_q[0] <= simplex ? tx_q : phase_q;
      end
      for (int k = 1; k < `RADIO_NR; k++) begin
        if (freq_wr_i.addr == cmd_addr_t'(`ADDR_RX1 + k - 1)) rx_q[k] <= phase_q;
      end
    end
  end

  assign tx_phase_o = tx_q;
  assign rx_phase_o = rx_q;

endmodule

// File: hdl/cw_shaper.sv
`timescale 1ns/1ps
`include "radio_defs.svh"

module cw_shaper import radio_ctrl_pkg::*; (
  input  logic      clk,
  input  logic      rst_n_i,
  input  logic      cw_key_i,
  output logic      tx_cw_key_o,
  output cw_level_t cw_level_o
);

  // Receive, key held down, ramping down after release
  typedef enum logic [1:0] {
    CW_RX,
    CW_DOWN,
    CW_UP
  } cw_state_t;

  cw_state_t state_q;
  cw_level_t level_q;

  // --------------------------------------------------
  // Key FSM and linear ramp
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= CW_RX;
      level_q <= '0;
    end else begin
      case (state_q)
        CW_RX: begin
          level_q <= '0;
          if (cw_key_i) state_q <= CW_DOWN;
        end
        CW_DOWN: begin
          // Rise one step per clock, hold at the cap
          if (level_q != `CW_MAX_LEVEL) level_q <= level_q + cw_level_t'(1);
          if (!cw_key_i) state_q <= CW_UP;
        end
        default: begin
          // Back to receive one edge after reaching zero
          if (level_q == '0) state_q <= CW_RX;
          else level_q <= level_q - cw_level_t'(1);
        end
      endcase
    end
  end

  // Transmitter stays keyed until the envelope is gone
  assign tx_cw_key_o = (state_q != CW_RX);
  assign cw_level_o  = level_q;

endmodule

// File: hdl/rx_frame_packer.sv
`timescale 1ns/1ps

module rx_frame_packer import radio_ctrl_pkg::*, radio_stream_pkg::*; (
  input  logic        clk,
  input  logic        rst_n_i,
  input  logic        rx_strobe_i,
  input  iq_bank_t    rx_iq_i,
  input  radio_ctrl_t ctrl_i,
  output rx_beat_t    rx_beat_o,
  output logic        rx_valid_o,
  input  logic        rx_ready_i
);

  logic     armed_q;
  logic     valid_q;
  // Low for I, high for Q
  logic     half_q;
  chan_t    chan_q;
  chan_t    last_q;
  iq_bank_t bank_q;
  logic     start;
  logic     accept;
  logic     final_beat;

  // New frame only from idle after the strobe went low
  assign start      = rx_strobe_i && armed_q && !valid_q;
  assign accept     = valid_q && rx_ready_i;
  assign final_beat = half_q && (chan_q == last_q);

  // --------------------------------------------------
  // Frame control
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      armed_q <= 1'b0;
      valid_q <= 1'b0;
      half_q  <= 1'b0;
      chan_q  <= '0;
    end else if (start) begin
      armed_q <= 1'b0;
      valid_q <= 1'b1;
      half_q  <= 1'b0;
      chan_q  <= '0;
    end else begin
      // Strobe low only counts while idle
      if (!valid_q && !rx_strobe_i) armed_q <= 1'b1;
      if (accept) begin
        if (!half_q) begin
          half_q <= 1'b1;
        end else if (final_beat) begin
          valid_q <= 1'b0;
        end else begin
          half_q <= 1'b0;
          chan_q <= chan_q + chan_t'(1);
        end
      end
    end
  end

  // Sample set and channel count frozen for the frame
  always_ff @(posedge clk) begin
    if (start) begin
      bank_q <= rx_iq_i;
      last_q <= ctrl_i.last_chan;
    end
  end

  // --------------------------------------------------
  // Beat output, held by the registers under back-pressure
  // --------------------------------------------------
  always_comb begin
    rx_beat_o.data = half_q ? bank_q[chan_q].q : bank_q[chan_q].i;
    rx_beat_o.last = final_beat;
  end

  assign rx_valid_o = valid_q;

endmodule

// File: hdl/radio_core.sv
`timescale 1ns/1ps

module radio_core import radio_ctrl_pkg::*, radio_stream_pkg::*; (
  input  logic        clk,
  input  logic        rst_n_i,
  // Command slave
  input  logic        cmd_rqst_i,
  input  cmd_addr_t   cmd_addr_i,
  input  cmd_data_t   cmd_data_i,
  output logic        cmd_ack_o,
  // NCO phase words
  output phase_t      tx_phase_o,
  output phase_bank_t rx_phase_o,
  // Receiver samples and upstream beats
  input  logic        rx_strobe_i,
  input  iq_bank_t    rx_iq_i,
  output rx_beat_t    rx_beat_o,
  output logic        rx_valid_o,
  input  logic        rx_ready_i,
  // CW keying
  input  logic        cw_key_i,
  output logic        tx_cw_key_o,
  output cw_level_t   cw_level_o
);

  radio_ctrl_t ctrl;
  freq_wr_t    freq_wr;

  // --------------------------------------------------
  // Decode
  // --------------------------------------------------
  cmd_decoder u_cmd_decoder (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .cmd_rqst_i (cmd_rqst_i),
    .cmd_addr_i (cmd_addr_i),
    .cmd_data_i (cmd_data_i),
    .cmd_ack_o  (cmd_ack_o),
    .ctrl_o     (ctrl),
    .freq_wr_o  (freq_wr)
  );

  // --------------------------------------------------
  // Execute
  // --------------------------------------------------
  phase_table u_phase_table (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .freq_wr_i  (freq_wr),
    .ctrl_i     (ctrl),
    .tx_phase_o (tx_phase_o),
    .rx_phase_o (rx_phase_o)
  );

  cw_shaper u_cw_shaper (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .cw_key_i    (cw_key_i),
    .tx_cw_key_o (tx_cw_key_o),
    .cw_level_o  (cw_level_o)
  );

  // --------------------------------------------------
  // Result
  // --------------------------------------------------
  rx_frame_packer u_rx_frame_packer (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .rx_strobe_i (rx_strobe_i),
    .rx_iq_i     (rx_iq_i),
    .ctrl_i      (ctrl),
    .rx_beat_o   (rx_beat_o),
    .rx_valid_o  (rx_valid_o),
    .rx_ready_i  (rx_ready_i)
  );

endmodule

// File: bench/radio_properties.sv
`timescale 1ns/1ps

module radio_properties import radio_stream_pkg::*; (
  input logic     clk,
  input logic     rst_n_i,
  input logic     valid_i,
  input logic     ready_i,
  input rx_beat_t beat_i,
  input logic     ack_i
);

  // Read by the testbench top for the final verdict
  int fail_count = 0;

  // Beat stays offered and unchanged until the sink takes it
  hold_until_ready: assert property (@(posedge clk) disable iff (!rst_n_i)
    valid_i && !ready_i |=> valid_i && $stable(beat_i))
    else begin
      fail_count++;
      $error("stream beat dropped or changed while ready was low");
    end

  // Ack is a single-cycle pulse
  ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n_i)
    ack_i |=> !ack_i)
    else begin
      fail_count++;
      $error("command ack held for more than one cycle");
    end

  // Synchronous reset clears the stream valid
  valid_low_after_reset: assert property (@(posedge clk) !rst_n_i |=> !valid_i)
    else begin
      fail_count++;
      $error("stream valid high after a reset edge");
    end

endmodule

// File: bench/radio_checker.sv
`timescale 1ns/1ps
`include "radio_defs.svh"

module radio_checker import radio_ctrl_pkg::*, radio_stream_pkg::*; (
  input  logic        clk,
  input  logic        rst_n_i,
  input  logic        cmd_rqst_i,
  input  cmd_addr_t   cmd_addr_i,
  input  cmd_data_t   cmd_data_i,
  input  logic        cmd_ack_i,
  input  phase_t      tx_phase_i,
  input  phase_bank_t rx_phase_i,
  input  logic        rx_strobe_i,
  input  iq_bank_t    rx_iq_i,
  input  rx_beat_t    rx_beat_i,
  input  logic        rx_valid_i,
  input  logic        rx_ready_i,
  input  logic        cw_key_i,
  input  logic        tx_cw_key_i,
  input  cw_level_t   cw_level_i,
  input  int          test_id_i,
  input  logic        run_done_i,
  input  int          prop_fails_i,
  output int          errors_o,
  output logic        report_done_o
);

  // Model state, stepped at each falling edge
  logic      synced = 1'b0;
  int        busy;
  cmd_addr_t m_addr;
  cmd_data_t m_data;
  chan_t     m_last;
  logic      m_duplex;
  phase_t    m_tx;
  phase_t    m_rx [`RADIO_NR];
  logic      m_armed;
  rx_beat_t  exp_q [$];
  // 0 receive, 1 key down, 2 ramp down
  int        m_cw_state;
  int        m_level;
  int        cur_test = 0;
  int        test_errs = 0;
  int        checks = 0;

  initial begin
    errors_o      = 0;
    report_done_o = 1'b0;
  end

  // --------------------------------------------------
  // Reference functions
  // --------------------------------------------------
  // Multiplier is 2^57 / 76.8 MHz, rounding term 2^24
  function automatic phase_t freq_to_phase(input cmd_data_t f);
    logic [63:0] p;
    p = 64'(f) * 64'd1876499845 + 64'd16777216;
    return p[56:25];
  endfunction

  // Last channel field clipped to the highest receiver
  function automatic chan_t clip_last(input logic [4:0] field);
    return (field > `RADIO_NR - 1) ? chan_t'(`RADIO_NR - 1) : field;
  endfunction

  function automatic string test_name(input int id);
    case (id)
      0:       return "reset";
      1:       return "frequency writes";
      2:       return "simplex rule";
      3:       return "frame contents";
      4:       return "back-pressure";
      default: return "cw envelope";
    endcase
  endfunction

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
      test_errs++;
      errors_o++;
    end
  endtask

  task automatic report_fail(input string what);
    $display("Error at %0t ns: %s", $time, what);
    test_errs++;
    errors_o++;
  endtask

  // --------------------------------------------------
  // Model steps
  // --------------------------------------------------
  task automatic reset_model();
    synced     = 1'b1;
    busy       = 0;
    m_last     = '0;
    m_duplex   = 1'b0;
    m_tx       = '0;
    foreach (m_rx[k]) m_rx[k] = '0;
    m_armed    = 1'b0;
    exp_q.delete();
    m_cw_state = 0;
    m_level    = 0;
  endtask

  task automatic step_command();
    logic   simplex;
    phase_t ph;
    simplex = !m_duplex && (m_last == 0);
    ph      = freq_to_phase(m_data);
    if (busy == 0 && cmd_rqst_i) begin
      if (cmd_addr_i == 6'h00) begin
        m_last   = clip_last(cmd_data_i[7:3]);
        m_duplex = cmd_data_i[2];
      end else if (cmd_addr_i <= 6'(1 + `RADIO_NR)) begin
        busy   = 1;
        m_addr = cmd_addr_i;
        m_data = cmd_data_i;
      end
    end else if (busy == 3) begin
      // Commit cycle, the phase rule applies here
      busy = 0;
      if (m_addr == 6'h01) begin
        m_tx = ph;
        if (simplex) m_rx[0] = ph;
      end else if (m_addr == 6'h02) begin
        m_rx[0] = simplex ? m_tx : ph;
      end else begin
        m_rx[m_addr - 2] = ph;
      end
    end else if (busy != 0) begin
      busy++;
    end
  endtask

  task automatic step_frame(input logic open);
    rx_beat_t b;
    if (rx_strobe_i && m_armed && !open) begin
      m_armed = 1'b0;
      for (int k = 0; k <= m_last; k++) begin
        b.data = rx_iq_i[k].i;
        b.last = 1'b0;
        exp_q.push_back(b);
        b.data = rx_iq_i[k].q;
        b.last = (k == m_last);
        exp_q.push_back(b);
      end
    end else if (!open && !rx_strobe_i) begin
      m_armed = 1'b1;
    end
  endtask

  task automatic step_cw();
    case (m_cw_state)
      0: begin
        m_level = 0;
        if (cw_key_i) m_cw_state = 1;
      end
      1: begin
        if (m_level < 'h4d800) m_level++;
        if (!cw_key_i) m_cw_state = 2;
      end
      default: begin
        if (m_level == 0) m_cw_state = 0;
        else m_level--;
      end
    endcase
  endtask

  // --------------------------------------------------
  // Compare at the falling edge, then advance the model
  // --------------------------------------------------
  always @(negedge clk) begin
    logic     open;
    rx_beat_t exp;
    if (test_id_i != cur_test) begin
      $display("test %0d %s: %0d errors", cur_test, test_name(cur_test), test_errs);
      cur_test  = test_id_i;
      test_errs = 0;
    end
    open = (exp_q.size() != 0);
    if (synced) begin
      compare("cmd_ack_o", cmd_ack_i, busy == 3);
      compare("tx_phase_o", tx_phase_i, m_tx);
      for (int k = 0; k < `RADIO_NR; k++) begin
        compare($sformatf("rx_phase_o[%0d]", k), rx_phase_i[k], m_rx[k]);
      end
      compare("rx_valid_o", rx_valid_i, open);
      compare("tx_cw_key_o", tx_cw_key_i, m_cw_state != 0);
      compare("cw_level_o", cw_level_i, m_level);
      if (rx_valid_i && rx_ready_i) begin
        if (exp_q.size() == 0) begin
          report_fail("a beat was transferred while no frame was open");
        end else begin
          exp = exp_q.pop_front();
          compare("rx_beat_o.data", rx_beat_i.data, exp.data);
          compare("rx_beat_o.last", rx_beat_i.last, exp.last);
        end
      end
    end
    if (!rst_n_i) begin
      reset_model();
    end else if (synced) begin
      // Frame start uses last_chan before any control write this edge
      step_frame(open);
      step_cw();
      step_command();
    end
    if (run_done_i && !report_done_o) begin
      if (exp_q.size() != 0) report_fail("frame beats were still owed at the end of the run");
      $display("test %0d %s: %0d errors", cur_test, test_name(cur_test), test_errs);
      $display("%0d checks, %0d mismatches, %0d assertion failures",
               checks, errors_o, prop_fails_i);
      report_done_o = 1'b1;
    end
  end

endmodule

// File: bench/radio_tb.sv
`timescale 1ns/1ps
`include "radio_defs.svh"

module radio_tb import radio_ctrl_pkg::*, radio_stream_pkg::*; ();

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 4;
  localparam int FREQ_ROUNDS  = 2;
  localparam int N_FRAMES     = 8;
  localparam int BP_CYCLES    = 300;
  localparam int N_KEYS       = 6;
  localparam int MAX_KEY      = 64;
  // About 8 cycles per command, 2*NR+8 per frame, twice each key length per press
  localparam int CYCLE_LIMIT  = 2 * (RESET_CYCLES + 8 * (FREQ_ROUNDS * (`RADIO_NR + 1) + 8)
                                + N_FRAMES * (2 * `RADIO_NR + 8) + BP_CYCLES
                                + 8 * `RADIO_NR + N_KEYS * (2 * MAX_KEY + 8)) + 100;

  logic        clk;
  logic        rst_n_i;
  logic        cmd_rqst_i;
  cmd_addr_t   cmd_addr_i;
  cmd_data_t   cmd_data_i;
  logic        cmd_ack_o;
  phase_t      tx_phase_o;
  phase_bank_t rx_phase_o;
  logic        rx_strobe_i;
  iq_bank_t    rx_iq_i;
  rx_beat_t    rx_beat_o;
  logic        rx_valid_o;
  logic        rx_ready_i;
  logic        cw_key_i;
  logic        tx_cw_key_o;
  cw_level_t   cw_level_o;
  int          test_id;
  logic        run_done;
  int          check_errors;
  logic        report_done;
  int          prop_fails;
  int          cycle_count = 0;
  logic [31:0] lfsr_q;

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  radio_core u_radio_core (.*);

  radio_checker u_radio_checker (
    .clk(clk), .rst_n_i(rst_n_i), .cmd_rqst_i(cmd_rqst_i), .cmd_addr_i(cmd_addr_i),
    .cmd_data_i(cmd_data_i), .cmd_ack_i(cmd_ack_o), .tx_phase_i(tx_phase_o),
    .rx_phase_i(rx_phase_o), .rx_strobe_i(rx_strobe_i), .rx_iq_i(rx_iq_i),
    .rx_beat_i(rx_beat_o), .rx_valid_i(rx_valid_o), .rx_ready_i(rx_ready_i),
    .cw_key_i(cw_key_i), .tx_cw_key_i(tx_cw_key_o), .cw_level_i(cw_level_o),
    .test_id_i(test_id), .run_done_i(run_done), .prop_fails_i(prop_fails),
    .errors_o(check_errors), .report_done_o(report_done)
  );

  // --------------------------------------------------
  // Handshake assertions on the stream and the command ack
  // --------------------------------------------------
  bind rx_frame_packer radio_properties u_packer_props (
    .clk(clk), .rst_n_i(rst_n_i), .valid_i(rx_valid_o), .ready_i(rx_ready_i),
    .beat_i(rx_beat_o), .ack_i(1'b0)
  );
  bind cmd_decoder radio_properties u_decoder_props (
    .clk(clk), .rst_n_i(rst_n_i), .valid_i(1'b0), .ready_i(1'b0),
    .beat_i('0), .ack_i(cmd_ack_o)
  );

  assign prop_fails = u_radio_core.u_rx_frame_packer.u_packer_props.fail_count +
                      u_radio_core.u_cmd_decoder.u_decoder_props.fail_count;

  // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int b = 0; b < n; b++) begin
      v      = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_step(lfsr_q);
    end
  endtask

  // Bits 7:3 last channel, bit 2 duplex
  function automatic cmd_data_t ctrl_word(input logic [4:0] last, input logic duplex);
    return {24'd0, last, duplex, 2'b00};
  endfunction

  // One request cycle, then junk on the data lines
  task automatic send_cmd(input cmd_addr_t addr, input cmd_data_t data, input logic wait_ack);
    logic [31:0] junk;
    @(posedge clk);
    cmd_rqst_i <= 1'b1;
    cmd_addr_i <= addr;
    cmd_data_i <= data;
    @(posedge clk);
    take_bits(32, junk);
    cmd_rqst_i <= 1'b0;
    cmd_data_i <= junk;
    if (wait_ack) begin
      do @(negedge clk); while (!cmd_ack_o);
    end
  endtask

  task automatic drive_random_bank();
    iq_bank_t    bank;
    logic [31:0] v;
    for (int k = 0; k < `RADIO_NR; k++) begin
      take_bits(24, v);
      bank[k].i = v[23:0];
      take_bits(24, v);
      bank[k].q = v[23:0];
    end
    rx_iq_i <= bank;
  endtask

  // --------------------------------------------------
  // Watchdog
  // --------------------------------------------------
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Errors found");
      $finish;
    end
  end

  initial begin
    logic [31:0] v;
    int          n;
    lfsr_q      = 32'h8692126c;
    rst_n_i     = 1'b0;
    cmd_rqst_i  = 1'b0;
    cmd_addr_i  = '0;
    cmd_data_i  = '0;
    rx_strobe_i = 1'b0;
    rx_iq_i     = '0;
    rx_ready_i  = 1'b1;
    cw_key_i    = 1'b0;
    test_id     = 0;
    run_done    = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n_i <= 1'b1;

    // Frequency writes to every phase address with duplex on
    test_id <= 1;
    send_cmd(`ADDR_CTRL, ctrl_word(5'(`RADIO_NR - 1), 1'b1), 1'b0);
    for (int r = 0; r < FREQ_ROUNDS; r++) begin
      for (int a = 1; a <= `RADIO_NR + 1; a++) begin
        take_bits(32, v);
        send_cmd(cmd_addr_t'(a), v, 1'b1);
      end
    end

    // Simplex writes RX0 first while it still differs from TX0
    // Then duplex, then a second channel without duplex
    test_id <= 2;
    for (int m = 0; m < 3; m++) begin
      send_cmd(`ADDR_CTRL, ctrl_word(5'(m == 2), m == 1), 1'b0);
      take_bits(32, v);
      send_cmd(`ADDR_RX0, v, 1'b1);
      take_bits(32, v);
      send_cmd(`ADDR_TX0, v, 1'b1);
    end

    // One frame per random control word with the sink always ready
    // Two bits of last channel give every count and one clipped value
    test_id <= 3;
    for (int f = 0; f < N_FRAMES; f++) begin
      take_bits(3, v);
      send_cmd(`ADDR_CTRL, ctrl_word(5'(v[2:1]), v[0]), 1'b0);
      @(posedge clk);
      rx_strobe_i <= 1'b1;
      drive_random_bank();
      @(posedge clk);
      rx_strobe_i <= 1'b0;
      drive_random_bank();
      do @(negedge clk); while (rx_valid_o);
    end

    // Random ready and strobes over all channels
    test_id <= 4;
    send_cmd(`ADDR_CTRL, ctrl_word(5'h1f, 1'b1), 1'b0);
    for (int c = 0; c < BP_CYCLES; c++) begin
      @(posedge clk);
      take_bits(1, v);
      rx_ready_i <= v[0];
      take_bits(2, v);
      rx_strobe_i <= (v[1:0] == 2'b11);
      drive_random_bank();
    end
    @(posedge clk);
    rx_ready_i  <= 1'b1;
    rx_strobe_i <= 1'b0;
    do @(negedge clk); while (rx_valid_o);

    // Key presses of random length
    test_id <= 5;
    for (int t = 0; t < N_KEYS; t++) begin
      take_bits(6, v);
      n = int'(v[5:0]) + 1;
      @(posedge clk);
      cw_key_i <= 1'b1;
      repeat (n) @(posedge clk);
      cw_key_i <= 1'b0;
      do @(negedge clk); while (tx_cw_key_o);
    end

    @(posedge clk);
    run_done <= 1'b1;
    while (!report_done) @(posedge clk);
    if (check_errors == 0 && prop_fails == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: files.f
+incdir+hdl
hdl/radio_ctrl_pkg.sv
hdl/radio_stream_pkg.sv
hdl/cmd_decoder.sv
hdl/phase_table.sv
hdl/cw_shaper.sv
hdl/rx_frame_packer.sv
hdl/radio_core.sv
bench/radio_properties.sv
bench/radio_checker.sv
bench/radio_tb.sv
